/* common/fft_pkg.sv */
package fft_pkg;

    // Stream geometry
    localparam int LANES       = 16;
    localparam int FRAME_BEATS = 32;
    localparam int HALF_BEATS  = 16;
    localparam int QUART_BEATS = 8;

    // Word growth is one bit per radix-2 stage
    localparam int IN_W = 9;
    localparam int S0_W = 10;
    localparam int S1_W = 11;

    // Window phase of the second stage
    typedef enum logic [1:0] {
        S1_IDLE,
        S1_SUM_HALF,
        S1_DIFF_HALF
    } s1_phase_e;

endpackage

/* source/shift_reg.sv */
module shift_reg
    import fft_pkg::*;
#(
    parameter int DEPTH = 16,
    parameter int W     = 9
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                shift_en_i,
    input  logic                valid_i,
    input  logic signed [W-1:0] din_re_i [LANES],
    input  logic signed [W-1:0] din_im_i [LANES],
    output logic                valid_o,
    output logic signed [W-1:0] dout_re_o[LANES],
    output logic signed [W-1:0] dout_im_o[LANES]
);

    logic [DEPTH-1:0]    valid_q;
    logic signed [W-1:0] re_q[DEPTH][LANES];
    logic signed [W-1:0] im_q[DEPTH][LANES];

    // Valid bit travels alongside the data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (shift_en_i) begin
            valid_q <= {valid_q[DEPTH-2:0], valid_i};
        end
    end

    always_ff @(posedge clk) begin
        if (shift_en_i) begin
            re_q[0] <= din_re_i;
            im_q[0] <= din_im_i;
            for (int i = 1; i < DEPTH; i++) begin
                re_q[i] <= re_q[i-1];
                im_q[i] <= im_q[i-1];
            end
        end
    end

    // Tail holds the entry from DEPTH shifts ago
    assign valid_o   = valid_q[DEPTH-1];
    assign dout_re_o = re_q[DEPTH-1];
    assign dout_im_o = im_q[DEPTH-1];

endmodule

/* source/butterfly.sv */
module butterfly
    import fft_pkg::*;
#(
    parameter int IN_W = 9
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 valid_i,
    input  logic signed [IN_W-1:0] a_re_i   [LANES],
    input  logic signed [IN_W-1:0] a_im_i   [LANES],
    input  logic signed [IN_W-1:0] b_re_i   [LANES],
    input  logic signed [IN_W-1:0] b_im_i   [LANES],
    output logic                 valid_o,
    output logic signed [IN_W:0]   sum_re_o [LANES],
    output logic signed [IN_W:0]   sum_im_o [LANES],
    output logic signed [IN_W:0]   diff_re_o[LANES],
    output logic signed [IN_W:0]   diff_im_o[LANES]
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // One extra bit per lane keeps a+b and a-b in range
    always_ff @(posedge clk) begin
        if (valid_i) begin
            for (int l = 0; l < LANES; l++) begin
                sum_re_o[l]  <= {a_re_i[l][IN_W-1], a_re_i[l]}
                              + {b_re_i[l][IN_W-1], b_re_i[l]};
                sum_im_o[l]  <= {a_im_i[l][IN_W-1], a_im_i[l]}
                              + {b_im_i[l][IN_W-1], b_im_i[l]};
                diff_re_o[l] <= {a_re_i[l][IN_W-1], a_re_i[l]}
                              - {b_re_i[l][IN_W-1], b_re_i[l]};
                diff_im_o[l] <= {a_im_i[l][IN_W-1], a_im_i[l]}
                              - {b_im_i[l][IN_W-1], b_im_i[l]};
            end
        end
    end

endmodule

/* step0/step0_0.sv */
module step0_0
    import fft_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   din_valid_i,
    input  logic signed [IN_W-1:0] din_re_i   [LANES],
    input  logic signed [IN_W-1:0] din_im_i   [LANES],
    output logic                   s0_valid_o,
    output logic signed [S0_W-1:0] s0_add_re_o[LANES],
    output logic signed [S0_W-1:0] s0_add_im_o[LANES],
    output logic signed [S0_W-1:0] s0_sub_re_o[LANES],
    output logic signed [S0_W-1:0] s0_sub_im_o[LANES]
);

    logic [4:0]              beat_cnt;
    logic                    dly_valid;
    logic signed [IN_W-1:0]  dly_re[LANES];
    logic signed [IN_W-1:0]  dly_im[LANES];
    logic                    bf_valid;

    // Position of the current input beat within the frame
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (din_valid_i) begin
            beat_cnt <= beat_cnt + 5'd1;
        end
    end

    // Holds the first half so sample n meets sample n+256
    shift_reg #(
        .DEPTH (HALF_BEATS),
        .W     (IN_W)
    ) dly_i (
        .clk        (clk),
        .rstn       (rstn),
        .shift_en_i (din_valid_i),
        .valid_i    (din_valid_i),
        .din_re_i   (din_re_i),
        .din_im_i   (din_im_i),
        .valid_o    (dly_valid),
        .dout_re_o  (dly_re),
        .dout_im_o  (dly_im)
    );

    // Second half of the frame, beats 16 to 31
    assign bf_valid = din_valid_i && (beat_cnt >= 5'(HALF_BEATS)) && dly_valid;

    butterfly #(
        .IN_W (IN_W)
    ) bf_i (
        .clk       (clk),
        .rstn      (rstn),
        .valid_i   (bf_valid),
        .a_re_i    (dly_re),
        .a_im_i    (dly_im),
        .b_re_i    (din_re_i),
        .b_im_i    (din_im_i),
        .valid_o   (s0_valid_o),
        .sum_re_o  (s0_add_re_o),
        .sum_im_o  (s0_add_im_o),
        .diff_re_o (s0_sub_re_o),
        .diff_im_o (s0_sub_im_o)
    );

endmodule

/* step0/step0_1.sv */
module step0_1
    import fft_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   s0_valid_i,
    input  logic signed [S0_W-1:0] s0_add_re_i  [LANES],
    input  logic signed [S0_W-1:0] s0_add_im_i  [LANES],
    input  logic signed [S0_W-1:0] s0_sub_re_i  [LANES],
    input  logic signed [S0_W-1:0] s0_sub_im_i  [LANES],
    output logic                   dout_valid_o,
    output logic signed [S1_W-1:0] dout_add_re_o[LANES],
    output logic signed [S1_W-1:0] dout_add_im_o[LANES],
    output logic signed [S1_W-1:0] dout_sub_re_o[LANES],
    output logic signed [S1_W-1:0] dout_sub_im_o[LANES]
);

    s1_phase_e               phase_q;
    s1_phase_e               cur_phase;
    logic [4:0]              win_cnt;
    logic                    win_active;

    logic                    diff_dly_valid;
    logic signed [S0_W-1:0]  diff_dly_re[LANES];
    logic signed [S0_W-1:0]  diff_dly_im[LANES];

    logic                    sel_valid;
    logic signed [S0_W-1:0]  sel_re[LANES];
    logic signed [S0_W-1:0]  sel_im[LANES];

    logic                    pair_valid;
    logic signed [S0_W-1:0]  pair_re[LANES];
    logic signed [S0_W-1:0]  pair_im[LANES];

    logic                    bf_valid;

    // First s0 beat of a frame is already window cycle 0
    always_comb begin
        cur_phase = phase_q;
        if (phase_q == S1_IDLE && s0_valid_i) begin
            cur_phase = S1_SUM_HALF;
        end
    end

    assign win_active = (cur_phase != S1_IDLE);

    // 32-cycle window, counter wraps back to 0 at the end
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase_q <= S1_IDLE;
            win_cnt <= '0;
        end else if (win_active) begin
            win_cnt <= win_cnt + 5'd1;
            if (win_cnt == 5'(HALF_BEATS - 1)) begin
                phase_q <= S1_DIFF_HALF;
            end else if (win_cnt == 5'(FRAME_BEATS - 1)) begin
                phase_q <= S1_IDLE;
            end else begin
                phase_q <= cur_phase;
            end
        end
    end

    // Difference half waits while the sum half is processed
    shift_reg #(
        .DEPTH (HALF_BEATS),
        .W     (S0_W)
    ) diff_dly_i (
        .clk        (clk),
        .rstn       (rstn),
        .shift_en_i (win_active),
        .valid_i    (s0_valid_i),
        .din_re_i   (s0_sub_re_i),
        .din_im_i   (s0_sub_im_i),
        .valid_o    (diff_dly_valid),
        .dout_re_o  (diff_dly_re),
        .dout_im_o  (diff_dly_im)
    );

    // Serialize sum half then difference half
    always_comb begin
        if (cur_phase == S1_DIFF_HALF) begin
            sel_valid = diff_dly_valid;
            sel_re    = diff_dly_re;
            sel_im    = diff_dly_im;
        end else begin
            sel_valid = s0_valid_i;
            sel_re    = s0_add_re_i;
            sel_im    = s0_add_im_i;
        end
    end

    // Pairs n with n+128 inside each half
    shift_reg #(
        .DEPTH (QUART_BEATS),
        .W     (S0_W)
    ) pair_dly_i (
        .clk        (clk),
        .rstn       (rstn),
        .shift_en_i (win_active),
        .valid_i    (sel_valid),
        .din_re_i   (sel_re),
        .din_im_i   (sel_im),
        .valid_o    (pair_valid),
        .dout_re_o  (pair_re),
        .dout_im_o  (pair_im)
    );

    // Beats 8 to 15 of each half
    assign bf_valid = win_active && (win_cnt[3:0] >= 4'(QUART_BEATS)) && pair_valid;

    butterfly #(
        .IN_W (S0_W)
    ) bf_i (
        .clk       (clk),
        .rstn      (rstn),
        .valid_i   (bf_valid),
        .a_re_i    (pair_re),
        .a_im_i    (pair_im),
        .b_re_i    (sel_re),
        .b_im_i    (sel_im),
        .valid_o   (dout_valid_o),
        .sum_re_o  (dout_add_re_o),
        .sum_im_o  (dout_add_im_o),
        .diff_re_o (dout_sub_re_o),
        .diff_im_o (dout_sub_im_o)
    );

endmodule

/* source/fft_front_top.sv */
module fft_front_top
    import fft_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   din_valid_i,
    input  logic signed [IN_W-1:0] din_re_i     [LANES],
    input  logic signed [IN_W-1:0] din_im_i     [LANES],
    output logic                   dout_valid_o,
    output logic signed [S1_W-1:0] dout_add_re_o[LANES],
    output logic signed [S1_W-1:0] dout_add_im_o[LANES],
    output logic signed [S1_W-1:0] dout_sub_re_o[LANES],
    output logic signed [S1_W-1:0] dout_sub_im_o[LANES]
);

    logic                   s0_valid;
    logic signed [S0_W-1:0] s0_add_re[LANES];
    logic signed [S0_W-1:0] s0_add_im[LANES];
    logic signed [S0_W-1:0] s0_sub_re[LANES];
    logic signed [S0_W-1:0] s0_sub_im[LANES];

    // n with n+256
    step0_0 step0_0_i (
        .clk         (clk),
        .rstn        (rstn),
        .din_valid_i (din_valid_i),
        .din_re_i    (din_re_i),
        .din_im_i    (din_im_i),
        .s0_valid_o  (s0_valid),
        .s0_add_re_o (s0_add_re),
        .s0_add_im_o (s0_add_im),
        .s0_sub_re_o (s0_sub_re),
        .s0_sub_im_o (s0_sub_im)
    );

    // n with n+128 in each half
    step0_1 step0_1_i (
        .clk           (clk),
        .rstn          (rstn),
        .s0_valid_i    (s0_valid),
        .s0_add_re_i   (s0_add_re),
        .s0_add_im_i   (s0_add_im),
        .s0_sub_re_i   (s0_sub_re),
        .s0_sub_im_i   (s0_sub_im),
        .dout_valid_o  (dout_valid_o),
        .dout_add_re_o (dout_add_re_o),
        .dout_add_im_o (dout_add_im_o),
        .dout_sub_re_o (dout_sub_re_o),
        .dout_sub_im_o (dout_sub_im_o)
    );

endmodule

/* verif/fft_front_model.svh */
`ifndef FFT_FRONT_MODEL_SVH
`define FFT_FRONT_MODEL_SVH

// Stored input frame, sample n sits at beat n/16 and lane n%16
int frame_re[LANES * FRAME_BEATS];
int frame_im[LANES * FRAME_BEATS];

// Expected results, one entry per lane in output order
int exp_add_re[$];
int exp_add_im[$];
int exp_sub_re[$];
int exp_sub_im[$];

// Galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h8020_0003;
    end
    return n;
endfunction

task automatic model_frame();
    int a_re[LANES * HALF_BEATS];
    int a_im[LANES * HALF_BEATS];
    int d_re[LANES * HALF_BEATS];
    int d_im[LANES * HALF_BEATS];
    int h_re[LANES * HALF_BEATS];
    int h_im[LANES * HALF_BEATS];
    int half_n;
    int quart_n;
    half_n  = LANES * HALF_BEATS;
    quart_n = LANES * QUART_BEATS;
    // First stage, n with n+256
    for (int n = 0; n < half_n; n++) begin
        a_re[n] = frame_re[n] + frame_re[n + half_n];
        a_im[n] = frame_im[n] + frame_im[n + half_n];
        d_re[n] = frame_re[n] - frame_re[n + half_n];
        d_im[n] = frame_im[n] - frame_im[n + half_n];
    end
    // Second stage on each half, sum half first
    for (int h = 0; h < 2; h++) begin
        if (h == 0) begin
            h_re = a_re;
            h_im = a_im;
        end else begin
            h_re = d_re;
            h_im = d_im;
        end
        for (int n = 0; n < quart_n; n++) begin
            exp_add_re.push_back(h_re[n] + h_re[n + quart_n]);
            exp_add_im.push_back(h_im[n] + h_im[n + quart_n]);
            exp_sub_re.push_back(h_re[n] - h_re[n + quart_n]);
            exp_sub_im.push_back(h_im[n] - h_im[n + quart_n]);
        end
    end
endtask

`endif

/* verif/fft_front_tb.sv */
module fft_front_tb
    import fft_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    logic                   clk;
    logic                   rstn;
    logic                   din_valid_i;
    logic signed [IN_W-1:0] din_re_i     [LANES];
    logic signed [IN_W-1:0] din_im_i     [LANES];
    logic                   dout_valid_o;
    logic signed [S1_W-1:0] dout_add_re_o[LANES];
    logic signed [S1_W-1:0] dout_add_im_o[LANES];
    logic signed [S1_W-1:0] dout_sub_re_o[LANES];
    logic signed [S1_W-1:0] dout_sub_im_o[LANES];

    logic [31:0] lfsr_state;
    int          frames_sent;
    int          out_beats;
    int          cycle_cnt;
    int          cycle_limit = 100000;
    int          gaps[6];
    int          gap_total;

    `include "fft_front_model.svh"

    fft_front_top fft_front_top_i (
        .clk           (clk),
        .rstn          (rstn),
        .din_valid_i   (din_valid_i),
        .din_re_i      (din_re_i),
        .din_im_i      (din_im_i),
        .dout_valid_o  (dout_valid_o),
        .dout_add_re_o (dout_add_re_o),
        .dout_add_im_o (dout_add_im_o),
        .dout_sub_re_o (dout_sub_re_o),
        .dout_sub_im_o (dout_sub_im_o)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int rand_sample();
        int s;
        s = int'(take_bits(IN_W));
        // Two's complement view of the raw bits
        if (s >= (1 << (IN_W - 1))) begin
            s = s - (1 << IN_W);
        end
        return s;
    endfunction

    // Kind 0 random, 1 all max, 2 all min, 3 max/min halves
    task automatic drive_frame(input int kind);
        int half_n;
        half_n = LANES * HALF_BEATS;
        for (int n = 0; n < LANES * FRAME_BEATS; n++) begin
            case (kind)
                1: begin
                    frame_re[n] = 255;
                    frame_im[n] = 255;
                end
                2: begin
                    frame_re[n] = -256;
                    frame_im[n] = -256;
                end
                3: begin
                    frame_re[n] = (n < half_n) ? 255 : -256;
                    frame_im[n] = (n < half_n) ? -256 : 255;
                end
                default: begin
                    frame_re[n] = rand_sample();
                    frame_im[n] = rand_sample();
                end
            endcase
        end
        model_frame();
        frames_sent++;
        for (int b = 0; b < FRAME_BEATS; b++) begin
            @(negedge clk);
            din_valid_i = 1'b1;
            for (int l = 0; l < LANES; l++) begin
                din_re_i[l] = IN_W'(frame_re[b * LANES + l]);
                din_im_i[l] = IN_W'(frame_im[b * LANES + l]);
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            din_valid_i = 1'b0;
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        // Last result leaves 17 cycles after the last input beat
        while (exp_add_re.size() > 0 && waited < FRAME_BEATS) begin
            @(negedge clk);
            din_valid_i = 1'b0;
            waited++;
        end
        // Watch a little longer for stray beats
        idle_cycles(16);
    endtask

    task automatic check_beat();
        if (exp_add_re.size() < LANES) begin
            $display("Output valid beat arrived with no expected result pending");
            abort_run();
        end else begin
            for (int l = 0; l < LANES; l++) begin
                check_value($sformatf("dout_add_re_o[%0d]", l), dout_add_re_o[l],
                            exp_add_re.pop_front());
                check_value($sformatf("dout_add_im_o[%0d]", l), dout_add_im_o[l],
                            exp_add_im.pop_front());
                check_value($sformatf("dout_sub_re_o[%0d]", l), dout_sub_re_o[l],
                            exp_sub_re.pop_front());
                check_value($sformatf("dout_sub_im_o[%0d]", l), dout_sub_im_o[l],
                            exp_sub_im.pop_front());
            end
            out_beats++;
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rstn && dout_valid_o) begin
            check_beat();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, expected output never arrived", cycle_cnt);
            abort_run();
        end
    end

    initial begin
        rstn        = 1'b0;
        din_valid_i = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            din_re_i[l] = '0;
            din_im_i[l] = '0;
        end
        lfsr_state = 32'hf1c8;

        // Gaps drawn up front so the cycle budget is known
        gap_total = 0;
        for (int g = 0; g < 6; g++) begin
            gaps[g]   = 1 + int'(take_bits(6)) % 40;
            gap_total = gap_total + gaps[g];
        end
        // Reset, idle test, 14 frames, gaps, 4 drains and margin
        cycle_limit = 16 + 40 + 14 * FRAME_BEATS + gap_total + 4 * (48 + 16) + 64;

        repeat (16) @(negedge clk);
        rstn = 1'b1;

        idle_cycles(40);
        check_value("dout beats with no input", out_beats, 0);

        drive_frame(0);
        drain_outputs();
        check_value("dout beats after one frame", out_beats, 2 * HALF_BEATS / 2);

        repeat (4) drive_frame(0);
        drain_outputs();
        check_value("dout beats after back-to-back frames", out_beats, 16 * frames_sent);

        for (int g = 0; g < 6; g++) begin
            drive_frame(0);
            idle_cycles(gaps[g]);
        end
        drain_outputs();
        check_value("dout beats after gapped frames", out_beats, 16 * frames_sent);

        // Full-scale inputs reach the edge of the output range
        drive_frame(1);
        drive_frame(2);
        drive_frame(3);
        drain_outputs();

        check_value("total dout beats", out_beats, 16 * frames_sent);
        check_value("expected beats left", exp_add_re.size(), 0);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+verif
common/fft_pkg.sv
source/shift_reg.sv
source/butterfly.sv
step0/step0_0.sv
step0/step0_1.sv
source/fft_front_top.sv
verif/fft_front_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module fft_front_tb -o fft_front_sim \
    && ./obj_dir/fft_front_sim | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }
